// File: hw/mdu_pkg.sv
`default_nettype none

package mdu_pkg;

  // Operand and result width of the unit
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      bit_cnt_t; // Serial bit or engine step count
  typedef logic [2:0]      mdu_op_t;

  // M-extension funct3 encodings, bit 2 marks the divide class
  localparam mdu_op_t OP_MUL    = 3'd0;
  localparam mdu_op_t OP_MULH   = 3'd1;
  localparam mdu_op_t OP_MULHSU = 3'd2;
  localparam mdu_op_t OP_MULHU  = 3'd3;
  localparam mdu_op_t OP_DIV    = 3'd4;
  localparam mdu_op_t OP_DIVU   = 3'd5;
  localparam mdu_op_t OP_REM    = 3'd6;
  localparam mdu_op_t OP_REMU   = 3'd7;

  typedef enum logic [1:0] {
    IDLE,
    GET,  // Gathering serial operands
    BUSY, // Engine running
    SEND  // Shifting result out
  } mdu_state_e;

  // Gathered operand pair for both engines
  typedef struct packed {
    word_t rs1;
    word_t rs2;
  } mdu_operands_t;

endpackage

`default_nettype wire

// File: hw/mdu_ctrl.sv
`default_nettype none

module mdu_ctrl (
  input  wire               i_clk,
  input  wire               i_rst,
  input  wire               i_mdu_valid,
  input  wire mdu_pkg::mdu_op_t i_mdu_op,
  input  wire               i_mul_done,
  input  wire               i_div_done,
  output logic              o_shift_en,
  output logic              o_mul_start,
  output logic              o_div_start,
  output logic              o_load,
  output logic              o_sel_div,
  output logic              o_mdu_ready,
  output mdu_pkg::mdu_op_t  o_op
);
  import mdu_pkg::*;

  mdu_state_e state_q;
  bit_cnt_t   cnt_q;
  mdu_op_t    op_q;
  logic       sel_div_q;
  logic       mul_start_q;
  logic       div_start_q;
  logic       eng_done;

  // Only the launched engine can finish
  assign eng_done = sel_div_q ? i_div_done : i_mul_done;

  // Valid cycle already carries bit 31
  assign o_shift_en  = ((state_q == IDLE) && i_mdu_valid) || (state_q == GET);
  assign o_load      = (state_q == BUSY) && eng_done;
  assign o_mdu_ready = (state_q == SEND);
  assign o_mul_start = mul_start_q;
  assign o_div_start = div_start_q;
  assign o_sel_div   = sel_div_q;
  assign o_op        = op_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q     <= IDLE;
      cnt_q       <= '0;
      op_q        <= OP_MUL;
      sel_div_q   <= 1'b0;
      mul_start_q <= 1'b0;
      div_start_q <= 1'b0;
    end else begin
      mul_start_q <= 1'b0; // One-cycle pulses
      div_start_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (i_mdu_valid) begin
            op_q      <= i_mdu_op;
            sel_div_q <= i_mdu_op[2];
            cnt_q     <= bit_cnt_t'(1); // First bit taken this cycle
            state_q   <= GET;
          end
        end
        GET: begin
          cnt_q <= cnt_q + 1'b1;
          if (&cnt_q) begin
            // Last operand bit lands at this edge
            mul_start_q <= ~op_q[2];
            div_start_q <= op_q[2];
            state_q     <= BUSY;
          end
        end
        BUSY: begin
          if (eng_done) begin
            cnt_q   <= '0;
            state_q <= SEND;
          end
        end
        SEND: begin
          cnt_q <= cnt_q + 1'b1;
          if (&cnt_q) begin
            state_q <= IDLE;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/mdu_operand_deser.sv
`default_nettype none

module mdu_operand_deser (
  input  wire                   i_clk,
  input  wire                   i_rst,
  input  wire                   i_shift_en,
  input  wire                   i_rs1_bit,
  input  wire                   i_rs2_bit,
  output mdu_pkg::mdu_operands_t o_operands
);
  import mdu_pkg::*;

  word_t rs1_q;
  word_t rs2_q;

  // MSB arrives first, so shift in at the bottom
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      rs1_q <= '0;
      rs2_q <= '0;
    end else if (i_shift_en) begin
      rs1_q <= {rs1_q[XLEN-2:0], i_rs1_bit};
      rs2_q <= {rs2_q[XLEN-2:0], i_rs2_bit};
    end
  end

  // Stays stable while the engines run
  always_comb begin
    o_operands.rs1 = rs1_q;
    o_operands.rs2 = rs2_q;
  end

endmodule

`default_nettype wire

// File: hw/mdu_mul.sv
`default_nettype none

module mdu_mul (
  input  wire                        i_clk,
  input  wire                        i_rst,
  input  wire                        i_start,
  input  wire mdu_pkg::mdu_op_t      i_op,
  input  wire mdu_pkg::mdu_operands_t i_operands,
  output logic                       o_done,
  output mdu_pkg::word_t             o_result
);
  import mdu_pkg::*;

  word_t             mcand_q;
  logic [2*XLEN-1:0] acc_q;   // {partial sum, remaining multiplier bits}
  logic              neg_q;
  logic              high_q;
  logic              busy_q;
  logic              done_q;
  bit_cnt_t          cnt_q;
  logic              a_signed;
  logic              b_signed;
  word_t             a_mag;
  word_t             b_mag;
  logic [XLEN:0]     sum;
  logic [2*XLEN-1:0] prod;

  always_comb begin
    a_signed = (i_op == OP_MULH) || (i_op == OP_MULHSU);
    b_signed = (i_op == OP_MULH);
    a_mag = (a_signed && i_operands.rs1[XLEN-1]) ? word_t'(-i_operands.rs1) : i_operands.rs1;
    b_mag = (b_signed && i_operands.rs2[XLEN-1]) ? word_t'(-i_operands.rs2) : i_operands.rs2;
    // Add multiplicand when current multiplier bit is set
    sum = {1'b0, acc_q[2*XLEN-1:XLEN]} + (acc_q[0] ? {1'b0, mcand_q} : '0);
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (i_start) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
      end else if (busy_q) begin
        cnt_q <= cnt_q + 1'b1;
        if (&cnt_q) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      mcand_q <= a_mag;
      acc_q   <= {{XLEN{1'b0}}, b_mag};
      neg_q   <= (a_signed & i_operands.rs1[XLEN-1]) ^ (b_signed & i_operands.rs2[XLEN-1]);
      high_q  <= (i_op != OP_MUL);
    end else if (busy_q) begin
      acc_q <= {sum, acc_q[XLEN-1:1]}; // Shift right one place per step
    end
  end

  // Sign fix-up and half select, held until next start
  assign prod     = neg_q ? -acc_q : acc_q;
  assign o_result = high_q ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];
  assign o_done   = done_q;

endmodule

`default_nettype wire

// File: hw/mdu_div.sv
`default_nettype none

module mdu_div (
  input  wire                        i_clk,
  input  wire                        i_rst,
  input  wire                        i_start,
  input  wire mdu_pkg::mdu_op_t      i_op,
  input  wire mdu_pkg::mdu_operands_t i_operands,
  output logic                       o_done,
  output mdu_pkg::word_t             o_result
);
  import mdu_pkg::*;

  word_t           quo_q;   // Dividend bits shift out, quotient bits shift in
  word_t           rem_q;
  word_t           dvsr_q;
  word_t           dvnd_q;  // Original dividend for divide by zero
  logic            q_neg_q;
  logic            r_neg_q;
  logic            rem_sel_q;
  logic            zero_q;
  logic            ovf_q;
  logic            busy_q;
  logic            done_q;
  bit_cnt_t        cnt_q;
  logic            signed_op;
  word_t           dvnd_mag;
  word_t           dvsr_mag;
  logic [XLEN:0]   rem_sh;
  logic [XLEN+1:0] diff;
  word_t           quo_fix;
  word_t           rem_fix;

  always_comb begin
    signed_op = ~i_op[0]; // DIV and REM
    dvnd_mag = (signed_op && i_operands.rs1[XLEN-1]) ? word_t'(-i_operands.rs1)
                                                      : i_operands.rs1;
    dvsr_mag = (signed_op && i_operands.rs2[XLEN-1]) ? word_t'(-i_operands.rs2)
                                                      : i_operands.rs2;
    // Trial subtract
    rem_sh = {rem_q, quo_q[XLEN-1]};
    diff   = {1'b0, rem_sh} - {2'b00, dvsr_q};
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (i_start) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
      end else if (busy_q) begin
        cnt_q <= cnt_q + 1'b1;
        if (&cnt_q) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      quo_q     <= dvnd_mag;
      rem_q     <= '0;
      dvsr_q    <= dvsr_mag;
      dvnd_q    <= i_operands.rs1;
      q_neg_q   <= signed_op & (i_operands.rs1[XLEN-1] ^ i_operands.rs2[XLEN-1]);
      r_neg_q   <= signed_op & i_operands.rs1[XLEN-1];
      rem_sel_q <= i_op[1];
      zero_q    <= (i_operands.rs2 == '0);
      ovf_q     <= signed_op && (i_operands.rs1 == {1'b1, {(XLEN-1){1'b0}}})
                   && (&i_operands.rs2);
    end else if (busy_q) begin
      if (!diff[XLEN+1]) begin // Restore not needed
        rem_q <= diff[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], 1'b1};
      end else begin
        rem_q <= rem_sh[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], 1'b0};
      end
    end
  end

  always_comb begin
    quo_fix = q_neg_q ? word_t'(-quo_q) : quo_q;
    rem_fix = r_neg_q ? word_t'(-rem_q) : rem_q;
    if (zero_q) begin
      quo_fix = '1;
      rem_fix = dvnd_q;
    end else if (ovf_q) begin
      quo_fix = dvnd_q; // Most negative value comes back unchanged
      rem_fix = '0;
    end
  end

  assign o_result = rem_sel_q ? rem_fix : quo_fix;
  assign o_done   = done_q;

endmodule

`default_nettype wire

// File: hw/mdu_result_ser.sv
`default_nettype none

module mdu_result_ser (
  input  wire                 i_clk,
  input  wire                 i_rst,
  input  wire                 i_load,
  input  wire mdu_pkg::word_t i_result,
  output logic                o_bit
);
  import mdu_pkg::*;

  word_t sr_q;

  // Zero fill keeps the line low once the word is out
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      sr_q <= '0;
    end else if (i_load) begin
      sr_q <= i_result;
    end else begin
      sr_q <= {sr_q[XLEN-2:0], 1'b0};
    end
  end

  assign o_bit = sr_q[XLEN-1]; // MSB first

endmodule

`default_nettype wire

// File: hw/mdu_top.sv
`default_nettype none

module mdu_top (
  input  wire                   i_clk,
  input  wire                   i_rst,
  input  wire                   i_mdu_rs1,
  input  wire                   i_mdu_rs2,
  input  wire                   i_mdu_valid,
  input  wire mdu_pkg::mdu_op_t i_mdu_op,
  output logic                  o_mdu_ready,
  output logic                  o_mdu_rd
);
  import mdu_pkg::*;

  logic          shift_en;
  logic          mul_start;
  logic          div_start;
  logic          mul_done;
  logic          div_done;
  logic          load;
  logic          sel_div;
  mdu_op_t       op;
  mdu_operands_t operands;
  word_t         mul_result;
  word_t         div_result;
  word_t         result;

  mdu_ctrl u_ctrl (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_mdu_valid (i_mdu_valid),
    .i_mdu_op    (i_mdu_op),
    .i_mul_done  (mul_done),
    .i_div_done  (div_done),
    .o_shift_en  (shift_en),
    .o_mul_start (mul_start),
    .o_div_start (div_start),
    .o_load      (load),
    .o_sel_div   (sel_div),
    .o_mdu_ready (o_mdu_ready),
    .o_op        (op)
  );

  mdu_operand_deser u_deser (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_shift_en (shift_en),
    .i_rs1_bit  (i_mdu_rs1),
    .i_rs2_bit  (i_mdu_rs2),
    .o_operands (operands)
  );

  mdu_mul u_mul (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_start    (mul_start),
    .i_op       (op),
    .i_operands (operands),
    .o_done     (mul_done),
    .o_result   (mul_result)
  );

  mdu_div u_div (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_start    (div_start),
    .i_op       (op),
    .i_operands (operands),
    .o_done     (div_done),
    .o_result   (div_result)
  );

  // Engine select for the serializer load
  assign result = sel_div ? div_result : mul_result;

  mdu_result_ser u_ser (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_load   (load),
    .i_result (result),
    .o_bit    (o_mdu_rd)
  );

endmodule

`default_nettype wire

// File: tests/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
  output logic o_clk
);
  localparam int HALF_PERIOD = 20; // 40 unit period

  initial o_clk = 1'b0;

  always #HALF_PERIOD o_clk = ~o_clk;

endmodule

`default_nettype wire

// File: tests/mdu_tb.sv
`default_nettype none

module mdu_tb;
  import mdu_pkg::*;

  localparam logic [31:0] SEED       = 32'hfa49_d8da;
  localparam int          WAIT_LIMIT = 200; // Cycles to wait for ready
  localparam word_t       MIN_NEG    = 32'h8000_0000;

  logic    clk;
  logic    rst;
  logic    rs1;
  logic    rs2;
  logic    valid;
  mdu_op_t op;
  logic    ready;
  logic    rd;

  int value_errors   = 0;
  int timeout_errors = 0;

  tb_clk_gen u_clk_gen (
    .o_clk (clk)
  );

  mdu_top DUT (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_mdu_rs1   (rs1),
    .i_mdu_rs2   (rs2),
    .i_mdu_valid (valid),
    .i_mdu_op    (op),
    .o_mdu_ready (ready),
    .o_mdu_rd    (rd)
  );

  // Reference results straight from the RISC-V M rules
  function automatic word_t expected_result(mdu_op_t op_in, word_t a, word_t b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] ub_s;
    logic [63:0]        ua;
    logic [63:0]        ub;
    logic [63:0]        p;
    logic signed [31:0] sa32;
    logic signed [31:0] sb32;
    logic               ovf;
    word_t              r;
    sa   = {{32{a[31]}}, a};
    sb   = {{32{b[31]}}, b};
    ua   = {32'b0, a};
    ub   = {32'b0, b};
    ub_s = ub; // Unsigned rs2 seen as a positive signed value
    sa32 = a;
    sb32 = b;
    ovf  = (a == MIN_NEG) && (b == '1);
    r    = '0;
    p    = '0;
    case (op_in)
      OP_MUL: begin
        p = ua * ub;
        r = p[31:0];
      end
      OP_MULH: begin
        p = sa * sb;
        r = p[63:32];
      end
      OP_MULHSU: begin
        p = sa * ub_s;
        r = p[63:32];
      end
      OP_MULHU: begin
        p = ua * ub;
        r = p[63:32];
      end
      OP_DIV: begin
        if (b == '0) r = '1;
        else if (ovf) r = a;
        else r = sa32 / sb32; // Truncates toward zero
      end
      OP_DIVU: begin
        if (b == '0) r = '1;
        else r = a / b;
      end
      OP_REM: begin
        if (b == '0) r = a;
        else if (ovf) r = '0;
        else r = sa32 % sb32; // Sign follows the dividend
      end
      default: begin
        if (b == '0) r = a;
        else r = a % b;
      end
    endcase
    return r;
  endfunction

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("error: %s expected %08h actual %08h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error: %s expected %b actual %b", name, exp, act);
      value_errors++;
    end
  endtask

  // One full request, called on a falling edge and returning on one
  task automatic run_op(input string name, input mdu_op_t op_in, input word_t a,
                        input word_t b, input bit poke);
    word_t got;
    int    wait_cnt;
    got = '0;
    for (int i = XLEN - 1; i >= 0; i--) begin
      valid = (i == XLEN - 1); // Valid rides with bit 31
      op    = op_in;
      rs1   = a[i];
      rs2   = b[i];
      @(negedge clk);
    end
    valid = 1'b0;
    rs1   = 1'b0;
    rs2   = 1'b0;
    if (poke) begin
      // Stray request while the engine runs
      valid = 1'b1;
      op    = mdu_op_t'($urandom);
      rs1   = 1'b1;
      rs2   = 1'b1;
      @(negedge clk);
      valid = 1'b0;
      rs1   = 1'b0;
      rs2   = 1'b0;
    end
    wait_cnt = 0;
    while (!ready && wait_cnt < WAIT_LIMIT) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (!ready) begin
      $display("%s: timed out waiting for the result to come back", name);
      timeout_errors++;
    end else begin
      for (int i = XLEN - 1; i >= 0; i--) begin
        check_level({name, " ready"}, 1'b1, ready);
        got[i] = rd;
        @(negedge clk);
      end
      check_level({name, " ready end"}, 1'b0, ready); // Exactly 32 cycles
      check_word(name, expected_result(op_in, a, b), got);
    end
  endtask

  initial begin
    word_t   a;
    word_t   b;
    mdu_op_t o;
    void'($urandom(SEED));
    rst   = 1'b1;
    valid = 1'b0;
    op    = OP_MUL;
    rs1   = 1'b0;
    rs2   = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    for (int k = 0; k < 8; k++) begin
      check_level("reset ready", 1'b0, ready);
      check_level("reset rd", 1'b0, rd);
      @(negedge clk);
    end

    // Multiply ops, first half with negative rs1
    for (int m = 0; m < 4; m++) begin
      for (int k = 0; k < 8; k++) begin
        a = $urandom;
        b = $urandom;
        if (k < 4) a[XLEN-1] = 1'b1;
        if (k[0]) b[XLEN-1] = 1'b1;
        run_op($sformatf("mul op%0d #%0d", m, k), mdu_op_t'(m), a, b, 1'b0);
      end
    end

    // Divide and remainder with mixed signs and sizes
    for (int d = 0; d < 4; d++) begin
      for (int k = 0; k < 8; k++) begin
        a = $urandom;
        b = $urandom >> ($urandom % 32);
        if ($urandom % 2 == 0) b = -b;
        run_op($sformatf("div op%0d #%0d", d + 4, k), mdu_op_t'(d + 4), a, b, 1'b0);
      end
    end

    for (int d = 0; d < 4; d++) begin
      o = mdu_op_t'(d + 4);
      run_op($sformatf("div0 op%0d", o), o, $urandom, '0, 1'b0);
      run_op($sformatf("div0 zero op%0d", o), o, '0, '0, 1'b0);
      run_op($sformatf("ovf op%0d", o), o, MIN_NEG, '1, 1'b0);
      run_op($sformatf("min by one op%0d", o), o, MIN_NEG, 32'd1, 1'b0);
    end

    // Busy-time valid pulses, requests back to back
    run_op("framing mulh", OP_MULH, $urandom, $urandom, 1'b1);
    run_op("framing rem", OP_REM, $urandom, $urandom, 1'b1);
    run_op("framing mul", OP_MUL, $urandom, $urandom, 1'b0);

    for (int k = 0; k < 200; k++) begin
      o = mdu_op_t'($urandom);
      a = $urandom;
      b = $urandom;
      if ($urandom % 8 == 0) b = '0;
      if ($urandom % 16 == 0) a = '0;
      run_op($sformatf("random #%0d op%0d", k, o), o, a, b, 1'b0);
    end

    $display("Errors: %0d value, %0d timeout", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: mdu_top.f
hw/mdu_pkg.sv
hw/mdu_ctrl.sv
hw/mdu_operand_deser.sv
hw/mdu_mul.sv
hw/mdu_div.sv
hw/mdu_result_ser.sv
hw/mdu_top.sv
tests/tb_clk_gen.sv
tests/mdu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the serial MDU testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
  --top-module mdu_tb \
  --Mdir obj_dir \
  -f mdu_top.f

./obj_dir/Vmdu_tb | tee sim.log

if grep -q "All tests passed!" sim.log; then
  echo "Simulation PASSED"
  exit 0
else
  echo "Simulation FAILED"
  exit 1
fi
